// File: source/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int data_width     = 32;
    localparam int line_width     = 128;
    localparam int words_per_line = line_width / data_width;
    localparam int set_count      = 256;
    localparam int index_width    = $clog2(set_count);
    localparam int offset_width   = $clog2(line_width / 8);
    localparam int tag_width      = data_width - index_width - offset_width;
    localparam int strb_width     = data_width / 8;

    typedef logic [tag_width-1:0]   tag_t;
    typedef logic [index_width-1:0] index_t;
    typedef logic [1:0]             word_sel_t;  // word within a line
    typedef logic [data_width-1:0]  word_t;
    typedef logic [strb_width-1:0]  strb_t;

    typedef word_t [words_per_line-1:0] line_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic                    op;        // 1 = store
        tag_t                    tag;
        index_t                  index;
        logic [offset_width-1:0] offset;
        word_t                   wdata;
        strb_t                   wstrb;
        logic                    uncached;
    } cpu_req_t;

endpackage

`default_nettype wire

// File: source/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    typedef logic [31:0] addr_t;

    // line bus, refill and victim traffic
    typedef struct packed {
        logic              rd_req;
        addr_t             rd_addr;    // line aligned
        logic              wr_req;
        addr_t             wr_addr;    // line aligned
        dcache_pkg::line_t wr_data;
    } line_bus_req_t;

    typedef struct packed {
        logic              rd_rdy;
        logic              ret_valid;
        dcache_pkg::line_t ret_data;   // valid with ret_valid only
        logic              wr_rdy;
        logic              wr_done;
    } line_bus_rsp_t;

    // word bus for uncached accesses
    typedef struct packed {
        logic              rd_req;
        logic              wr_req;
        addr_t             addr;       // full byte address
        dcache_pkg::word_t wr_data;
        dcache_pkg::strb_t wr_strb;
    } word_bus_req_t;

    typedef struct packed {
        logic              rd_rdy;
        logic              wr_rdy;
        logic              ret_valid;
        logic              wr_done;
        dcache_pkg::word_t ret_data;
    } word_bus_rsp_t;

endpackage

`default_nettype wire

// File: source/ram_sync.sv
`timescale 1ns/100ps
`default_nettype none

module ram_sync #(
    parameter int  depth      = 256,
    parameter type entry_t    = logic [31:0],
    localparam int addr_width = $clog2(depth)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  logic [addr_width-1:0] waddr,
    input  entry_t                wdata,
    input  logic [addr_width-1:0] raddr,
    output entry_t                rdata
);

    entry_t mem [depth];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;  // invalid and clean
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];  // old data on same-address write
    end

endmodule

`default_nettype wire

// File: source/cache_line_path.sv
`timescale 1ns/100ps
`default_nettype none

module cache_line_path (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  dcache_pkg::cpu_req_t       held_req,
    input  dcache_pkg::index_t         lookup_index,
    input  mem_bus_pkg::line_bus_rsp_t line_rsp,
    output dcache_pkg::word_t          rdata,
    output logic                       busy,
    output mem_bus_pkg::line_bus_req_t line_req
);

    import dcache_pkg::*;

    typedef enum logic [2:0] {
        s_lookup,
        s_miss_dirty,
        s_write_back,
        s_miss_clean,
        s_refill,
        s_replay,
        s_store_merge,
        s_store_write
    } state_t;

    state_t     state;
    state_t     state_next;
    logic       recheck;     // load after replay, arrays hold the new line
    logic       go;
    logic       hit;
    logic       refill_we;
    logic       dirty_we;
    logic       dirty_rd;
    index_t     read_index;
    word_sel_t  word_sel;
    tag_entry_t tag_rd;
    tag_entry_t tag_wdata;
    word_t      data_rd [words_per_line];
    logic       bank_we [words_per_line];
    word_t      bank_wdata [words_per_line];
    word_t      merged_word;
    word_t      merge_q;

    assign go        = start | recheck;
    assign hit       = tag_rd.valid && (tag_rd.tag == held_req.tag);
    assign word_sel  = held_req.offset[offset_width-1:2];
    assign rdata     = data_rd[word_sel];
    assign refill_we = (state == s_refill) && line_rsp.ret_valid;
    assign dirty_we  = refill_we || (state == s_store_write);
    assign tag_wdata = '{valid: 1'b1, tag: held_req.tag};

    // a load hit leaves busy low, so the next request may read this cycle
    assign busy = (state == s_lookup) ? (go && (!hit || held_req.op)) : 1'b1;

    assign read_index = (state == s_lookup && !busy) ? lookup_index : held_req.index;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= s_lookup;
            recheck <= 1'b0;
        end else begin
            state   <= state_next;
            recheck <= (state == s_replay);
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            s_lookup: begin
                if (go && !hit) begin
                    state_next = (tag_rd.valid && dirty_rd) ? s_miss_dirty : s_miss_clean;
                end else if (go && held_req.op) begin
                    state_next = s_store_write;  // merge already taken this cycle
                end
            end
            s_miss_dirty:
                if (line_rsp.wr_rdy)
                    state_next = s_write_back;
            s_write_back:
                if (line_rsp.wr_done)
                    state_next = s_miss_clean;
            s_miss_clean:
                if (line_rsp.rd_rdy)
                    state_next = s_refill;
            s_refill:
                if (line_rsp.ret_valid)
                    state_next = s_replay;
            s_replay:
                state_next = held_req.op ? s_store_merge : s_lookup;
            s_store_merge:
                state_next = s_store_write;
            s_store_write:
                state_next = s_lookup;
            default:
                state_next = s_lookup;
        endcase
    end

    // byte merge of store data into the stored word
    always_comb begin
        for (int b = 0; b < strb_width; b++) begin
            merged_word[8*b +: 8] = held_req.wstrb[b] ? held_req.wdata[8*b +: 8]
                                                      : rdata[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_lookup || state == s_store_merge)
            merge_q <= merged_word;
    end

    always_comb begin
        for (int w = 0; w < words_per_line; w++) begin
            bank_we[w]    = refill_we || (state == s_store_write && word_sel == w);
            bank_wdata[w] = (state == s_refill) ? line_rsp.ret_data[w] : merge_q;
        end
    end

    // victim comes from the still-addressed set
    always_comb begin
        line_req.rd_req  = (state == s_miss_clean);
        line_req.rd_addr = {held_req.tag, held_req.index, {offset_width{1'b0}}};
        line_req.wr_req  = (state == s_miss_dirty);
        line_req.wr_addr = {tag_rd.tag, held_req.index, {offset_width{1'b0}}};
        for (int w = 0; w < words_per_line; w++) begin
            line_req.wr_data[w] = data_rd[w];
        end
    end

    ram_sync #(
        .depth   (set_count),
        .entry_t (tag_entry_t)
    ) tag_ram (
        .clk   (clk),
        .reset (reset),
        .we    (refill_we),
        .waddr (held_req.index),
        .wdata (tag_wdata),
        .raddr (read_index),
        .rdata (tag_rd)
    );

    ram_sync #(
        .depth   (set_count),
        .entry_t (logic)
    ) dirty_ram (
        .clk   (clk),
        .reset (reset),
        .we    (dirty_we),
        .waddr (held_req.index),
        .wdata (state == s_store_write),  // refill cleans, store dirties
        .raddr (read_index),
        .rdata (dirty_rd)
    );

    for (genvar w = 0; w < words_per_line; w++) begin : g_bank
        ram_sync #(
            .depth   (set_count),
            .entry_t (word_t)
        ) data_ram (
            .clk   (clk),
            .reset (reset),
            .we    (bank_we[w]),
            .waddr (held_req.index),
            .wdata (bank_wdata[w]),
            .raddr (read_index),
            .rdata (data_rd[w])
        );
    end

endmodule

`default_nettype wire

// File: source/uncached_path.sv
`timescale 1ns/100ps
`default_nettype none

module uncached_path (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  dcache_pkg::cpu_req_t       held_req,
    input  mem_bus_pkg::word_bus_rsp_t word_rsp,
    output dcache_pkg::word_t          rdata,
    output logic                       busy,
    output logic                       done,
    output mem_bus_pkg::word_bus_req_t word_req
);

    typedef enum logic [2:0] {
        s_idle,
        s_load,
        s_store,
        s_wait_ret,
        s_done
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk) begin
        if (reset)
            state <= s_idle;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            s_idle:
                if (start)
                    state_next = held_req.op ? s_store : s_load;
            s_load:
                if (word_rsp.rd_rdy)
                    state_next = s_wait_ret;
            s_store:
                if (word_rsp.wr_rdy)
                    state_next = s_wait_ret;
            s_wait_ret:
                if (held_req.op ? word_rsp.wr_done : word_rsp.ret_valid)
                    state_next = s_done;
            default:
                state_next = s_idle;  // done lasts one cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == s_wait_ret && word_rsp.ret_valid)
            rdata <= word_rsp.ret_data;
    end

    assign busy = (state == s_idle && start) || state == s_load || state == s_store
                  || state == s_wait_ret;
    assign done = (state == s_done);

    assign word_req.rd_req  = (state == s_load);
    assign word_req.wr_req  = (state == s_store);
    assign word_req.addr    = {held_req.tag, held_req.index, held_req.offset};
    assign word_req.wr_data = held_req.wdata;
    assign word_req.wr_strb = held_req.wstrb;

endmodule

`default_nettype wire

// File: source/dcache_request_stage.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_request_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid,
    input  dcache_pkg::cpu_req_t req,
    input  dcache_pkg::word_t    cache_rdata,
    input  logic                 cache_busy,
    input  dcache_pkg::word_t    uncached_rdata,
    input  logic                 uncached_busy,
    input  logic                 uncached_done,
    output dcache_pkg::cpu_req_t held_req,
    output dcache_pkg::index_t   lookup_index,
    output logic                 cache_start,
    output logic                 uncached_start,
    output dcache_pkg::word_t    rdata,
    output logic                 busy
);

    // request buffer, stable until the next accepted request
    always_ff @(posedge clk) begin
        if (req_valid)
            held_req <= req;
    end

    // one start pulse per request, in the cycle after acceptance
    always_ff @(posedge clk) begin
        if (reset) begin
            cache_start    <= 1'b0;
            uncached_start <= 1'b0;
        end else begin
            cache_start    <= req_valid && !req.uncached;
            uncached_start <= req_valid && req.uncached;
        end
    end

    // arrays start reading in the request cycle
    assign lookup_index = req.index;

    assign rdata = uncached_done ? uncached_rdata : cache_rdata;
    assign busy  = cache_busy | uncached_busy;

endmodule

`default_nettype wire

// File: source/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req_valid,
    input  dcache_pkg::cpu_req_t       req,
    input  mem_bus_pkg::line_bus_rsp_t line_rsp,
    input  mem_bus_pkg::word_bus_rsp_t word_rsp,
    output dcache_pkg::word_t          rdata,
    output logic                       busy,
    output mem_bus_pkg::line_bus_req_t line_req,
    output mem_bus_pkg::word_bus_req_t word_req
);

    import dcache_pkg::*;

    cpu_req_t held_req;
    index_t   lookup_index;
    logic     cache_start;
    logic     uncached_start;
    word_t    cache_rdata;
    word_t    uncached_rdata;
    logic     cache_busy;
    logic     uncached_busy;
    logic     uncached_done;

    dcache_request_stage request_stage (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req            (req),
        .cache_rdata    (cache_rdata),
        .cache_busy     (cache_busy),
        .uncached_rdata (uncached_rdata),
        .uncached_busy  (uncached_busy),
        .uncached_done  (uncached_done),
        .held_req       (held_req),
        .lookup_index   (lookup_index),
        .cache_start    (cache_start),
        .uncached_start (uncached_start),
        .rdata          (rdata),
        .busy           (busy)
    );

    cache_line_path line_path (
        .clk          (clk),
        .reset        (reset),
        .start        (cache_start),
        .held_req     (held_req),
        .lookup_index (lookup_index),
        .line_rsp     (line_rsp),
        .rdata        (cache_rdata),
        .busy         (cache_busy),
        .line_req     (line_req)
    );

    uncached_path word_path (
        .clk      (clk),
        .reset    (reset),
        .start    (uncached_start),
        .held_req (held_req),
        .word_rsp (word_rsp),
        .rdata    (uncached_rdata),
        .busy     (uncached_busy),
        .done     (uncached_done),
        .word_req (word_req)
    );

endmodule

`default_nettype wire

// File: tests/dcache_checker.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_checker (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req_valid,
    input  dcache_pkg::cpu_req_t       req,
    input  dcache_pkg::word_t          rdata,
    input  logic                       busy,
    input  mem_bus_pkg::line_bus_req_t line_req,
    input  mem_bus_pkg::line_bus_rsp_t line_rsp,
    input  mem_bus_pkg::word_bus_req_t word_req,
    input  mem_bus_pkg::word_bus_rsp_t word_rsp,
    input  int                         case_id,
    input  dcache_pkg::word_t          case_load_data,
    output int                         data_errors,
    output int                         bus_errors,
    output int                         protocol_errors,
    output int                         done_count
);

    import dcache_pkg::*;

    word_t       ref_mem [logic [31:0]];  // memory in program order
    logic        ref_valid [set_count];
    tag_t        ref_tag [set_count];
    logic        ref_dirty [set_count];
    logic        started;
    logic        in_flight;
    logic        first_cycle;  // cycle after issue
    logic        exp_busy;
    cpu_req_t    cur_req;
    int          cur_id;
    word_t       cur_load_data;
    logic        exp_line_rd;
    logic        exp_line_wb;
    logic        exp_word_rd;
    logic        exp_word_wr;
    logic [31:0] exp_rd_addr;
    logic [31:0] exp_wb_addr;

    initial begin
        data_errors     = 0;
        bus_errors      = 0;
        protocol_errors = 0;
        done_count      = 0;
    end

    function automatic logic [31:0] request_address(cpu_req_t r);
        return {r.tag, r.index, r.offset};
    endfunction

    // untouched words follow the address pattern
    function automatic word_t memory_word(logic [31:0] addr);
        logic [31:0] aligned;
        aligned = {addr[31:2], 2'b00};
        if (ref_mem.exists(aligned))
            return ref_mem[aligned];
        return aligned ^ 32'h5a5a_0000;
    endfunction

    function automatic word_t merge_bytes(word_t old_word, word_t new_word, strb_t strb);
        word_t result;
        for (int b = 0; b < strb_width; b++) begin
            result[8*b +: 8] = strb[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
        end
        return result;
    endfunction

    task automatic compare_word(input string signal, input logic [31:0] expected,
                                input logic [31:0] actual, input bit load_data);
        if (actual !== expected) begin
            if (load_data)
                data_errors++;
            else
                bus_errors++;
            $display("error at %0t: %s expected %0h, got %0h", $time, signal, expected, actual);
        end
    endtask

    task automatic clear_reference();
        for (int s = 0; s < set_count; s++) begin
            ref_valid[s] = 1'b0;
            ref_tag[s]   = '0;
            ref_dirty[s] = 1'b0;
        end
        started     = 1'b0;
        in_flight   = 1'b0;
        first_cycle = 1'b0;
        exp_line_rd = 1'b0;
        exp_line_wb = 1'b0;
        exp_word_rd = 1'b0;
        exp_word_wr = 1'b0;
    endtask

    task automatic check_idle();
        if ({busy, line_req.rd_req, line_req.wr_req, word_req.rd_req, word_req.wr_req} !== 5'b0) begin
            protocol_errors++;
            $display("busy or a bus request is not low at %0t before the first request", $time);
        end
    endtask

    // only a cached load hit keeps busy low in cycle 1
    task automatic check_first_busy();
        if (busy !== exp_busy) begin
            protocol_errors++;
            $display("error at %0t: busy (case %0d) expected %0b, got %0b", $time, cur_id,
                     exp_busy, busy);
        end
        first_cycle = 1'b0;
    endtask

    task automatic watch_line_bus();
        if (line_req.wr_req && line_rsp.wr_rdy) begin
            if (!in_flight || !exp_line_wb) begin
                bus_errors++;
                $display("unexpected line write-back to %h at %0t", line_req.wr_addr, $time);
            end else begin
                compare_word("line_req.wr_addr", exp_wb_addr, line_req.wr_addr, 1'b0);
                for (int w = 0; w < words_per_line; w++) begin
                    compare_word($sformatf("line_req.wr_data[%0d]", w),
                                 memory_word(exp_wb_addr + 4 * w), line_req.wr_data[w], 1'b0);
                end
                exp_line_wb = 1'b0;
            end
        end
        if (line_req.rd_req && line_rsp.rd_rdy) begin
            if (!in_flight || !exp_line_rd || exp_line_wb) begin
                bus_errors++;
                $display("unexpected line read of %h at %0t", line_req.rd_addr, $time);
            end else begin
                compare_word("line_req.rd_addr", exp_rd_addr, line_req.rd_addr, 1'b0);
                exp_line_rd = 1'b0;
            end
        end
    endtask

    task automatic watch_word_bus();
        if (word_req.rd_req && word_rsp.rd_rdy) begin
            if (!in_flight || !exp_word_rd) begin
                bus_errors++;
                $display("unexpected word bus load from %h at %0t", word_req.addr, $time);
            end else begin
                compare_word("word_req.addr", request_address(cur_req), word_req.addr, 1'b0);
                exp_word_rd = 1'b0;
            end
        end
        if (word_req.wr_req && word_rsp.wr_rdy) begin
            if (!in_flight || !exp_word_wr) begin
                bus_errors++;
                $display("unexpected word bus store to %h at %0t", word_req.addr, $time);
            end else begin
                compare_word("word_req.addr", request_address(cur_req), word_req.addr, 1'b0);
                compare_word("word_req.wr_data", cur_req.wdata, word_req.wr_data, 1'b0);
                compare_word("word_req.wr_strb", cur_req.wstrb, word_req.wr_strb, 1'b0);
                exp_word_wr = 1'b0;
            end
        end
    endtask

    task automatic start_case();
        index_t idx;
        logic   hit;
        cur_req       = req;
        cur_id        = case_id;
        cur_load_data = case_load_data;
        idx           = req.index;
        exp_word_rd   = req.uncached && !req.op;
        exp_word_wr   = req.uncached && req.op;
        exp_line_rd   = 1'b0;
        exp_line_wb   = 1'b0;
        exp_busy      = 1'b1;
        if (!req.uncached) begin
            hit = ref_valid[idx] && (ref_tag[idx] == req.tag);
            exp_busy = !hit || req.op;
            if (!hit) begin
                exp_line_rd = 1'b1;
                exp_rd_addr = {req.tag, idx, 4'h0};
                exp_line_wb = ref_valid[idx] && ref_dirty[idx];
                exp_wb_addr = {ref_tag[idx], idx, 4'h0};
                ref_dirty[idx] = req.op;  // refill comes in clean
            end else begin
                ref_dirty[idx] = ref_dirty[idx] | req.op;
            end
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = req.tag;
        end
        in_flight   = 1'b1;
        started     = 1'b1;
        first_cycle = 1'b1;
    endtask

    task automatic finish_case();
        logic [31:0] addr;
        if (exp_line_rd || exp_line_wb || exp_word_rd || exp_word_wr) begin
            bus_errors++;
            $display("case %0d finished at %0t without its expected bus transfer", cur_id, $time);
        end
        addr = request_address(cur_req);
        if (cur_req.op)
            ref_mem[{addr[31:2], 2'b00}] = merge_bytes(memory_word(addr), cur_req.wdata,
                                                       cur_req.wstrb);
        else
            compare_word($sformatf("rdata (case %0d)", cur_id), cur_load_data, rdata, 1'b1);
        in_flight = 1'b0;
        done_count++;
    endtask

    // inputs are sampled before the edge updates them
    always @(posedge clk) begin
        if (reset) begin
            clear_reference();
        end else begin
            if (!started)
                check_idle();
            watch_line_bus();
            watch_word_bus();
            if (first_cycle)
                check_first_busy();
            if (in_flight && busy === 1'b0)
                finish_case();
            if (req_valid)
                start_case();
        end
    end

endmodule

`default_nettype wire

// File: tests/dcache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tb;

    import dcache_pkg::*;
    import mem_bus_pkg::*;

    typedef struct packed {
        logic        op;
        logic [31:0] addr;
        word_t       wdata;
        strb_t       wstrb;
        logic        uncached;
        word_t       load_data;
    } test_case_t;

    logic          clk;
    logic          reset;
    logic          req_valid;
    cpu_req_t      req;
    line_bus_rsp_t line_rsp;
    word_bus_rsp_t word_rsp;
    word_t         rdata;
    logic          busy;
    line_bus_req_t line_req;
    word_bus_req_t word_req;
    int            case_id;
    word_t         case_load_data;
    int            data_errors;
    int            bus_errors;
    int            protocol_errors;
    int            done_count;
    int            case_count;
    bit            cases_loaded;
    bit            load_ok;
    integer        seed = 77994;
    test_case_t    cases [$];
    word_t         mem_words [logic [31:0]];  // sparse backing memory

    dcache_top UUT (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .line_rsp  (line_rsp),
        .word_rsp  (word_rsp),
        .rdata     (rdata),
        .busy      (busy),
        .line_req  (line_req),
        .word_req  (word_req)
    );

    dcache_checker scoreboard (
        .clk             (clk),
        .reset           (reset),
        .req_valid       (req_valid),
        .req             (req),
        .rdata           (rdata),
        .busy            (busy),
        .line_req        (line_req),
        .line_rsp        (line_rsp),
        .word_req        (word_req),
        .word_rsp        (word_rsp),
        .case_id         (case_id),
        .case_load_data  (case_load_data),
        .data_errors     (data_errors),
        .bus_errors      (bus_errors),
        .protocol_errors (protocol_errors),
        .done_count      (done_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int random_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    function automatic word_t read_word(logic [31:0] addr);
        logic [31:0] aligned;
        aligned = {addr[31:2], 2'b00};
        if (mem_words.exists(aligned))
            return mem_words[aligned];
        return aligned ^ 32'h5a5a_0000;
    endfunction

    task automatic write_word(input logic [31:0] addr, input word_t data, input strb_t strb);
        word_t old_word;
        old_word = read_word(addr);
        for (int b = 0; b < strb_width; b++) begin
            if (strb[b])
                old_word[8*b +: 8] = data[8*b +: 8];
        end
        mem_words[{addr[31:2], 2'b00}] = old_word;
    endtask

    task automatic serve_line_write();
        logic [31:0] addr;
        line_t       victim;
        repeat (random_delay()) @(posedge clk);
        line_rsp.wr_rdy <= 1'b1;
        @(posedge clk);
        line_rsp.wr_rdy <= 1'b0;
        addr   = line_req.wr_addr;
        victim = line_req.wr_data;
        for (int w = 0; w < words_per_line; w++) begin
            write_word(addr + 4 * w, victim[w], 4'hf);
        end
        repeat (random_delay()) @(posedge clk);
        line_rsp.wr_done <= 1'b1;
        @(posedge clk);
        line_rsp.wr_done <= 1'b0;
    endtask

    task automatic serve_line_read();
        logic [31:0] addr;
        line_t       fill;
        repeat (random_delay()) @(posedge clk);
        line_rsp.rd_rdy <= 1'b1;
        @(posedge clk);
        line_rsp.rd_rdy <= 1'b0;
        addr = line_req.rd_addr;
        for (int w = 0; w < words_per_line; w++) begin
            fill[w] = read_word(addr + 4 * w);
        end
        repeat (random_delay()) @(posedge clk);
        line_rsp.ret_data  <= fill;
        line_rsp.ret_valid <= 1'b1;
        @(posedge clk);
        line_rsp.ret_valid <= 1'b0;
        line_rsp.ret_data  <= '0;
    endtask

    task automatic serve_word_read();
        logic [31:0] addr;
        repeat (random_delay()) @(posedge clk);
        word_rsp.rd_rdy <= 1'b1;
        @(posedge clk);
        word_rsp.rd_rdy <= 1'b0;
        addr = word_req.addr;
        repeat (random_delay()) @(posedge clk);
        word_rsp.ret_data  <= read_word(addr);
        word_rsp.ret_valid <= 1'b1;
        @(posedge clk);
        word_rsp.ret_valid <= 1'b0;
        word_rsp.ret_data  <= '0;
    endtask

    task automatic serve_word_write();
        repeat (random_delay()) @(posedge clk);
        word_rsp.wr_rdy <= 1'b1;
        @(posedge clk);
        word_rsp.wr_rdy <= 1'b0;
        write_word(word_req.addr, word_req.wr_data, word_req.wr_strb);
        repeat (random_delay()) @(posedge clk);
        word_rsp.wr_done <= 1'b1;
        @(posedge clk);
        word_rsp.wr_done <= 1'b0;
    endtask

    initial begin : line_bus_model
        wait (cases_loaded && !reset);
        forever begin
            @(posedge clk);
            if (line_req.wr_req)
                serve_line_write();
            else if (line_req.rd_req)
                serve_line_read();
        end
    end

    initial begin : word_bus_model
        wait (cases_loaded && !reset);
        forever begin
            @(posedge clk);
            if (word_req.wr_req)
                serve_word_write();
            else if (word_req.rd_req)
                serve_word_read();
        end
    end

    task automatic load_cases(output bit ok);
        int                 fd;
        int                 n;
        logic [8*128-1:0]   text;
        logic [31:0]        f_op;
        logic [31:0]        f_addr;
        logic [31:0]        f_wdata;
        logic [31:0]        f_wstrb;
        logic [31:0]        f_uncached;
        logic [31:0]        f_load;
        test_case_t         tc;
        ok = 1'b0;
        fd = $fopen("tests/dcache_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                text = '0;
                n    = $fgets(text, fd);
                if (n > 0 && $sscanf(text, "%h %h %h %h %h %h", f_op, f_addr, f_wdata,
                                     f_wstrb, f_uncached, f_load) == 6) begin
                    tc.op        = f_op[0];
                    tc.addr      = f_addr;
                    tc.wdata     = f_wdata;
                    tc.wstrb     = f_wstrb[3:0];
                    tc.uncached  = f_uncached[0];
                    tc.load_data = f_load;
                    cases.push_back(tc);
                end
            end
            $fclose(fd);
            ok = 1'b1;
        end
    endtask

    task automatic issue_case(input int id);
        test_case_t tc;
        cpu_req_t   r;
        tc                         = cases[id];
        r.op                       = tc.op;
        {r.tag, r.index, r.offset} = tc.addr;
        r.wdata                    = tc.wdata;
        r.wstrb                    = tc.wstrb;
        r.uncached                 = tc.uncached;
        req            <= r;
        req_valid      <= 1'b1;
        case_id        <= id;
        case_load_data <= tc.load_data;
    endtask

    // one request per free cycle, never back to back
    task automatic run_cases();
        int next;
        next = 0;
        while (next < case_count) begin
            @(posedge clk);
            if (!busy && !req_valid) begin
                issue_case(next);
                next++;
            end else begin
                req_valid <= 1'b0;
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    initial begin : watchdog
        wait (cases_loaded);
        repeat (case_count * 40 + 8) @(posedge clk);
        $display("timeout: only %0d of %0d cases finished in time", done_count, case_count);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset          = 1'b1;
        req_valid      = 1'b0;
        req            = '0;
        line_rsp       = '0;
        word_rsp       = '0;
        case_id        = 0;
        case_load_data = '0;
        cases_loaded   = 1'b0;
        load_cases(load_ok);
        case_count = cases.size();
        if (!load_ok || case_count == 0) begin
            $display("no cases could be read from tests/dcache_cases.txt");
            $display("Test failed");
            $finish;
        end else begin
            cases_loaded = 1'b1;
            repeat (3) @(posedge clk);
            reset <= 1'b0;
            repeat (4) @(posedge clk);  // idle after reset
            run_cases();
            wait (done_count == case_count);
            repeat (2) @(posedge clk);
            $display("errors: %0d load data, %0d bus traffic, %0d protocol; %0d of %0d cases done",
                     data_errors, bus_errors, protocol_errors, done_count, case_count);
            if (data_errors + bus_errors + protocol_errors == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tests/dcache_cases.txt
// op address wdata wstrb uncached load_data, all hex, one request per line
// op 1 is a store; load_data is ignored for stores
0 00001004 00000000 0 0 5a5a1004
0 0000100c 00000000 0 0 5a5a100c
1 00001008 deadbeef 3 0 00000000
0 00001008 00000000 0 0 5a5abeef
1 00001000 11223344 c 0 00000000
0 00002008 00000000 0 0 5a5a2008
0 00001008 00000000 0 0 5a5abeef
0 00001000 00000000 0 0 11221000
0 00003010 00000000 0 1 5a5a3010
1 00003020 cafef00d f 1 00000000
0 00003020 00000000 0 1 cafef00d
1 00003024 0000ab00 2 1 00000000
0 00003024 00000000 0 0 5a5aab24
0 00003020 00000000 0 0 cafef00d
0 00001004 00000000 0 1 5a5a1004
0 00001004 00000000 0 0 5a5a1004
1 00004034 55667788 1 0 00000000
0 00004034 00000000 0 0 5a5a4088
1 00004030 a0b0c0d0 9 0 00000000
1 00005038 01020304 f 0 00000000
0 00005038 00000000 0 0 01020304
0 00004034 00000000 0 0 5a5a4088
0 00004030 00000000 0 0 a05a40d0
0 0000503c 00000000 0 0 5a5a503c
0 00005038 00000000 0 0 01020304
0 00fff0f0 00000000 0 0 5aa5f0f0
1 00fff0fc 12345678 6 0 00000000
0 00fff0fc 00000000 0 0 5a3456fc
0 01000000 00000000 0 0 5b5a0000
0 00002000 00000000 0 0 5a5a2000

// File: filelist.f
source/dcache_pkg.sv
source/mem_bus_pkg.sv
source/ram_sync.sv
source/cache_line_path.sv
source/uncached_path.sv
source/dcache_request_stage.sv
source/dcache_top.sv
tests/dcache_checker.sv
tests/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - source/dcache_pkg.sv
  - source/mem_bus_pkg.sv
  - source/ram_sync.sv
  - source/cache_line_path.sv
  - source/uncached_path.sv
  - source/dcache_request_stage.sv
  - source/dcache_top.sv
  - target: test
    files:
      - tests/dcache_checker.sv
      - tests/dcache_tb.sv
